//--- source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN      32
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000

// major opcodes
`define TY_BASE 6'b100000
`define ADDI    6'b101000
`define ORI     6'b101100
`define XORI    6'b101011
`define MOVI    6'b100010
`define LWI     6'b000010
`define SWI     6'b001010
`define TY_LS   6'b011100
`define TY_B    6'b100110
`define JJ      6'b100100

// base sub-opcodes in the low 5 bits of sub_op
`define ADD   5'b00000
`define SUB   5'b00001
`define AND   5'b00010
`define XOR   5'b00011
`define OR    5'b00100
`define SLLI  5'b01000
`define SRLI  5'b01001
`define ROTRI 5'b01011

`define LW 8'b00000010
`define SW 8'b00001010

`define BEQ 1'b0
`define BNE 1'b1

// second ALU operand
`define SRC2_RB       3'd0
`define SRC2_IMM      3'd1
`define SRC2_IMM15    3'd2
`define SRC2_RB_SHIFT 3'd3
`define SRC2_RT       3'd4

`define EXT_SHAMT  2'd0
`define EXT_SIGN15 2'd1
`define EXT_ZERO15 2'd2
`define EXT_SIGN20 2'd3

`define WB_ALU  2'd0
`define WB_IMM  2'd1
`define WB_LOAD 2'd2

`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_XOR 3'd4
`define ALU_SRL 3'd5
`define ALU_SLL 3'd6
`define ALU_ROR 3'd7

`define PC_NEXT   2'd0
`define PC_BRANCH 2'd1
`define PC_JUMP   2'd2

`endif

//--- source/cpu_pkg.sv
package cpu_pkg;

	typedef struct packed {
		logic       spare;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		// also the shift immediate
		logic [4:0] rb;
		logic [1:0] sv;
		logic [7:0] sub_op;
	} reg_form_t;

	typedef struct packed {
		logic        spare;
		logic [5:0]  opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm15;
	} imm_form_t;

	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} instr_t;

	typedef struct packed {
		logic [2:0] alu_src2_select;
		logic [1:0] imm_extend_select;
		logic [1:0] write_reg_select;
		logic [2:0] alu_op;
		logic [1:0] pc_select;
		logic       dm_read;
		logic       dm_write;
		logic       reg_write;
	} ctrl_t;

	typedef enum logic [2:0] {
		S_FETCH     = 3'd0,
		S_DECODE    = 3'd1,
		S_EXECUTE   = 3'd2,
		S_MEMACCESS = 3'd3,
		S_WRITEBACK = 3'd4
	} stage_t;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
	input  logic [`XLEN-1:0] operand_a,
	input  logic [`XLEN-1:0] operand_b,
	input  logic [2:0]       alu_op,
	output logic [`XLEN-1:0] result,
	output logic             zero
);

	logic [4:0]         shamt;
	logic [2*`XLEN-1:0] rotated;

	assign shamt = operand_b[4:0];
	// rotate right through a doubled word
	assign rotated = {operand_a, operand_a} >> shamt;

	always_comb begin
		case (alu_op)
			`ALU_ADD: result = operand_a + operand_b;
			`ALU_SUB: result = operand_a - operand_b;
			`ALU_AND: result = operand_a & operand_b;
			`ALU_OR:  result = operand_a | operand_b;
			`ALU_XOR: result = operand_a ^ operand_b;
			`ALU_SRL: result = operand_a >> shamt;
			`ALU_SLL: result = operand_a << shamt;
			default:  result = rotated[`XLEN-1:0];
		endcase
	end

	// equality test for branches after sub
	assign zero = (result == '0);

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [$clog2(`REG_COUNT)-1:0] ra_addr,
	input  logic [$clog2(`REG_COUNT)-1:0] rb_addr,
	input  logic [$clog2(`REG_COUNT)-1:0] write_addr,
	input  logic                          write_enable,
	input  logic [`XLEN-1:0]              write_data,
	output logic [`XLEN-1:0]              ra_data,
	output logic [`XLEN-1:0]              rb_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

endmodule

//--- source/controller.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module controller import cpu_pkg::*; (
	input  logic   clock,
	input  logic   reset,
	input  instr_t instruction,
	input  logic   alu_zero,
	output stage_t stage,
	output instr_t instr,
	output ctrl_t  ctrl
);

	ctrl_t dec;
	logic  branch_taken;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			stage <= S_FETCH;
		end else begin
			case (stage)
				S_FETCH:     stage <= S_DECODE;
				S_DECODE:    stage <= S_EXECUTE;
				S_EXECUTE:   stage <= S_MEMACCESS;
				S_MEMACCESS: stage <= S_WRITEBACK;
				default:     stage <= S_FETCH;
			endcase
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr <= '0;
		end else if (stage == S_FETCH) begin
			instr <= instruction;
		end
	end

	// branch outcome held from execute until writeback
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			branch_taken <= 1'b0;
		end else if (stage == S_EXECUTE) begin
			if (instr.imm_form.opcode == `TY_B) begin
				branch_taken <= (instr.imm_form.imm15[14] == `BEQ) ? alu_zero : !alu_zero;
			end else begin
				branch_taken <= 1'b0;
			end
		end
	end

	always_comb begin
		dec = '0;
		case (instr.reg_form.opcode)
			`TY_BASE: begin
				dec.reg_write = 1'b1;
				case (instr.reg_form.sub_op[4:0])
					`ADD: dec.alu_op = `ALU_ADD;
					`SUB: dec.alu_op = `ALU_SUB;
					`AND: dec.alu_op = `ALU_AND;
					`OR:  dec.alu_op = `ALU_OR;
					`XOR: dec.alu_op = `ALU_XOR;
					`SRLI: begin
						dec.alu_op = `ALU_SRL;
						dec.alu_src2_select = `SRC2_IMM;
					end
					`SLLI: begin
						dec.alu_op = `ALU_SLL;
						dec.alu_src2_select = `SRC2_IMM;
					end
					`ROTRI: begin
						dec.alu_op = `ALU_ROR;
						dec.alu_src2_select = `SRC2_IMM;
					end
					default: dec.reg_write = 1'b0;
				endcase
			end
			`ADDI: begin
				dec.alu_src2_select = `SRC2_IMM;
				dec.imm_extend_select = `EXT_SIGN15;
				dec.reg_write = 1'b1;
			end
			`ORI, `XORI: begin
				dec.alu_src2_select = `SRC2_IMM;
				dec.imm_extend_select = `EXT_ZERO15;
				dec.alu_op = (instr.reg_form.opcode == `ORI) ? `ALU_OR : `ALU_XOR;
				dec.reg_write = 1'b1;
			end
			`MOVI: begin
				dec.imm_extend_select = `EXT_SIGN20;
				dec.write_reg_select = `WB_IMM;
				dec.reg_write = 1'b1;
			end
			`LWI: begin
				dec.alu_src2_select = `SRC2_IMM15;
				dec.write_reg_select = `WB_LOAD;
				dec.dm_read = 1'b1;
				dec.reg_write = 1'b1;
			end
			`SWI: begin
				dec.alu_src2_select = `SRC2_IMM15;
				dec.dm_write = 1'b1;
			end
			`TY_LS: begin
				dec.alu_src2_select = `SRC2_RB_SHIFT;
				if (instr.reg_form.sub_op == `LW) begin
					dec.write_reg_select = `WB_LOAD;
					dec.dm_read = 1'b1;
					dec.reg_write = 1'b1;
				end else if (instr.reg_form.sub_op == `SW) begin
					dec.dm_write = 1'b1;
				end
			end
			`TY_B: begin
				dec.alu_src2_select = `SRC2_RT;
				dec.alu_op = `ALU_SUB;
				dec.pc_select = branch_taken ? `PC_BRANCH : `PC_NEXT;
			end
			`JJ: dec.pc_select = `PC_JUMP;
			default: dec = '0;
		endcase
	end

	// strobes only in their own state
	always_comb begin
		ctrl = dec;
		ctrl.dm_read = dec.dm_read && (stage == S_MEMACCESS);
		ctrl.dm_write = dec.dm_write && (stage == S_MEMACCESS);
		ctrl.reg_write = dec.reg_write && (stage == S_WRITEBACK);
	end

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath import cpu_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  stage_t           stage,
	input  instr_t           instr,
	input  ctrl_t            ctrl,
	output logic [`XLEN-1:0] instruction_addr,
	output logic [`XLEN-1:0] data_addr,
	output logic [`XLEN-1:0] data_wdata,
	input  logic [`XLEN-1:0] data_rdata,
	output logic             alu_zero
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] store_data;
	logic [`XLEN-1:0] alu_out;
	logic [`XLEN-1:0] load_data;
	logic [`XLEN-1:0] ra_data;
	logic [`XLEN-1:0] rb_data;
	logic [`XLEN-1:0] ext_imm;
	logic [`XLEN-1:0] sext15;
	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] write_data;
	logic [4:0]       rb_addr;
	logic [14:0]      imm15;
	logic [19:0]      imm20;
	logic [23:0]      imm24;

	assign imm15 = instr.imm_form.imm15;
	assign imm20 = {instr.imm_form.ra, imm15};
	assign imm24 = {instr.imm_form.rt[3:0], instr.imm_form.ra, imm15};
	assign sext15 = {{(`XLEN-15){imm15[14]}}, imm15};

	// rt in execute for the store data, and in decode for compares
	assign rb_addr = (stage == S_EXECUTE || ctrl.alu_src2_select == `SRC2_RT) ?
		instr.reg_form.rt : instr.reg_form.rb;

	register_file u_register_file (
		.clock       (clock),
		.reset       (reset),
		.ra_addr     (instr.reg_form.ra),
		.rb_addr     (rb_addr),
		.write_addr  (instr.reg_form.rt),
		.write_enable(ctrl.reg_write),
		.write_data  (write_data),
		.ra_data     (ra_data),
		.rb_data     (rb_data)
	);

	always_comb begin
		case (ctrl.imm_extend_select)
			`EXT_SHAMT:  ext_imm = {{(`XLEN-5){1'b0}}, instr.reg_form.rb};
			`EXT_SIGN15: ext_imm = sext15;
			`EXT_ZERO15: ext_imm = {{(`XLEN-15){1'b0}}, imm15};
			default:     ext_imm = {{(`XLEN-20){imm20[19]}}, imm20};
		endcase
		case (ctrl.alu_src2_select)
			`SRC2_IMM:      alu_b = ext_imm;
			`SRC2_IMM15:    alu_b = {sext15[`XLEN-3:0], 2'b00};
			`SRC2_RB_SHIFT: alu_b = op_b << instr.reg_form.sv;
			default:        alu_b = op_b;
		endcase
		case (ctrl.write_reg_select)
			`WB_IMM:  write_data = ext_imm;
			`WB_LOAD: write_data = load_data;
			default:  write_data = alu_out;
		endcase
	end

	alu u_alu (
		.operand_a(op_a),
		.operand_b(alu_b),
		.alu_op   (ctrl.alu_op),
		.result   (alu_result),
		.zero     (alu_zero)
	);

	always_ff @(posedge clock) begin
		if (stage == S_DECODE) begin
			op_a <= ra_data;
			op_b <= rb_data;
		end
		if (stage == S_EXECUTE) begin
			alu_out <= alu_result;
			store_data <= rb_data;
		end
		if (ctrl.dm_read) begin
			load_data <= data_rdata;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (stage == S_WRITEBACK) begin
			case (ctrl.pc_select)
				`PC_BRANCH: pc <= pc + {{(`XLEN-15){imm15[13]}}, imm15[13:0], 1'b0};
				`PC_JUMP:   pc <= pc + {{(`XLEN-25){imm24[23]}}, imm24, 1'b0};
				default:    pc <= pc + 4;
			endcase
		end
	end

	assign instruction_addr = pc;
	assign data_addr = alu_out;
	assign data_wdata = store_data;

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top import cpu_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	output logic [`XLEN-1:0] im_addr,
	input  logic [`XLEN-1:0] instruction,
	output logic [`XLEN-1:0] dm_addr,
	output logic [`XLEN-1:0] dm_wdata,
	input  logic [`XLEN-1:0] dm_rdata,
	output logic             dm_read,
	output logic             dm_write
);

	stage_t stage;
	instr_t instr;
	ctrl_t  ctrl;
	logic   alu_zero;

	controller u_controller (
		.clock      (clock),
		.reset      (reset),
		.instruction(instruction),
		.alu_zero   (alu_zero),
		.stage      (stage),
		.instr      (instr),
		.ctrl       (ctrl)
	);

	datapath u_datapath (
		.clock           (clock),
		.reset           (reset),
		.stage           (stage),
		.instr           (instr),
		.ctrl            (ctrl),
		.instruction_addr(im_addr),
		.data_addr       (dm_addr),
		.data_wdata      (dm_wdata),
		.data_rdata      (dm_rdata),
		.alu_zero        (alu_zero)
	);

	assign dm_read = ctrl.dm_read;
	assign dm_write = ctrl.dm_write;

endmodule

//--- dv/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions import cpu_pkg::*; (
	input logic   clock,
	input logic   reset,
	input stage_t stage,
	input logic   dm_read,
	input logic   dm_write
);

	a_strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high in the same cycle");

	a_strobe_in_memaccess: assert property (@(posedge clock) disable iff (reset)
		(dm_read || dm_write) |-> (stage == S_MEMACCESS))
		else $error("memory strobe outside the memory access state");

	a_stage_wraps: assert property (@(posedge clock) disable iff (reset)
		(stage == S_WRITEBACK) |=> (stage == S_FETCH))
		else $error("writeback not followed by fetch");

	// every other state steps to the next one
	a_stage_steps: assert property (@(posedge clock) disable iff (reset)
		(stage != S_WRITEBACK) |=> (stage == stage_t'($past(stage) + 3'd1)))
		else $error("stage did not advance in order");

endmodule

bind controller cpu_assertions u_assertions (
	.clock   (clock),
	.reset   (reset),
	.stage   (stage),
	.dm_read (ctrl.dm_read),
	.dm_write(ctrl.dm_write)
);

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

	typedef enum {
		T_ADD, T_SUB, T_AND, T_OR, T_XOR, T_ADDI, T_ORI, T_XORI, T_SRLI, T_SLLI, T_ROTRI,
		T_LWI, T_LW, T_BEQ_TAKEN, T_BEQ_NOT, T_BNE_TAKEN, T_BNE_NOT, T_JJ
	} test_e;

	localparam int NUM_TESTS = 23;

	test_e tests [NUM_TESTS] = '{
		T_ADD, T_SUB, T_AND, T_OR, T_XOR, T_ADDI, T_ADDI, T_ORI, T_XORI, T_SRLI, T_SLLI,
		T_ROTRI, T_ROTRI, T_LWI, T_LW, T_LW, T_LW, T_LW,
		T_BEQ_TAKEN, T_BEQ_NOT, T_BNE_TAKEN, T_BNE_NOT, T_JJ
	};

	logic        clock;
	logic        reset;
	logic [31:0] im_addr;
	logic [31:0] instruction;
	logic [31:0] dm_addr;
	logic [31:0] dm_wdata;
	logic [31:0] dm_rdata;
	logic        dm_read;
	logic        dm_write;

	logic [31:0] imem [512];
	logic [31:0] dmem [logic [31:0]];
	logic [8:0]  pc_word = 9'd0;
	int          slot = 0;
	logic [31:0] lcg_state = 32'd94;
	string       exp_name [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	cpu_top u_dut (
		.clock      (clock),
		.reset      (reset),
		.im_addr    (im_addr),
		.instruction(instruction),
		.dm_addr    (dm_addr),
		.dm_wdata   (dm_wdata),
		.dm_rdata   (dm_rdata),
		.dm_read    (dm_read),
		.dm_write   (dm_write)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	// both memories answer within the cycle
	always @(negedge clock) begin
		instruction <= imem[im_addr[10:2]];
		dm_rdata <= dm_read ? dmem[dm_addr] : 32'd0;
		if (dm_write) begin
			dmem[dm_addr] = dm_wdata;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[15:0], lcg_state[31:16]};
	endfunction

	function automatic logic [31:0] sext20(input logic [31:0] v);
		return {{12{v[19]}}, v[19:0]};
	endfunction

	// reference results for the ALU style operations
	function automatic logic [31:0] model(input test_e t, input logic [31:0] a,
			input logic [31:0] b);
		case (t)
			T_ADD, T_ADDI: return a + b;
			T_SUB:         return a - b;
			T_AND:         return a & b;
			T_OR, T_ORI:   return a | b;
			T_XOR, T_XORI: return a ^ b;
			T_SRLI:        return a >> b[4:0];
			T_SLLI:        return a << b[4:0];
			T_ROTRI:       return (a >> b[4:0]) | (a << (6'd32 - {1'b0, b[4:0]}));
			default:       return a;
		endcase
	endfunction

	function automatic logic [4:0] sub_of(input test_e t);
		case (t)
			T_SUB:   return `SUB;
			T_AND:   return `AND;
			T_OR:    return `OR;
			T_XOR:   return `XOR;
			T_SRLI:  return `SRLI;
			T_SLLI:  return `SLLI;
			T_ROTRI: return `ROTRI;
			default: return `ADD;
		endcase
	endfunction

	function automatic instr_t enc_imm(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		instr_t w;
		w.imm_form = '{1'b0, op, rt, ra, imm};
		return w;
	endfunction

	function automatic instr_t enc_reg(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv,
			input logic [7:0] sub);
		instr_t w;
		w.reg_form = '{1'b0, op, rt, ra, rb, sv, sub};
		return w;
	endfunction

	task automatic emit(input instr_t w);
		imem[pc_word] = w;
		pc_word++;
	endtask

	task automatic movi(input logic [4:0] rt, input logic [31:0] v);
		emit(enc_imm(`MOVI, rt, v[19:15], v[14:0]));
	endtask

	task automatic expect_store(input string name, input logic [31:0] addr,
			input logic [31:0] data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// SWI to a fresh word that is expected only when not skipped
	task automatic store_slot(input string name, input logic [4:0] rt,
			input logic [31:0] data, input logic expected);
		emit(enc_imm(`SWI, rt, 5'd0, 15'(64 + slot)));
		if (expected) begin
			expect_store(name, 32'h100 + slot * 4, data);
		end
		slot++;
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] ext;
		logic [31:0] addr;
		logic [14:0] imm;
		logic [5:0]  op;
		logic [1:0]  sv;
		logic        taken;
		string       name;
		test_e       t;
		sv = 2'd0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			t = tests[i];
			name = $sformatf("%s_%0d", t.name(), i);
			a = sext20(lcg_next());
			b = sext20(lcg_next());
			r = lcg_next();
			imm = {1'b1, r[13:0]};
			movi(5'd1, a);
			case (t)
				T_ADD, T_SUB, T_AND, T_OR, T_XOR: begin
					movi(5'd2, b);
					emit(enc_reg(`TY_BASE, 5'd3, 5'd1, 5'd2, 2'd0, {3'b000, sub_of(t)}));
					store_slot(name, 5'd3, model(t, a, b), 1'b1);
				end
				T_SRLI, T_SLLI, T_ROTRI: begin
					emit(enc_reg(`TY_BASE, 5'd3, 5'd1, r[4:0], 2'd0, {3'b000, sub_of(t)}));
					store_slot(name, 5'd3, model(t, a, {27'd0, r[4:0]}), 1'b1);
				end
				T_ADDI, T_ORI, T_XORI: begin
					// only ADDI sign-extends
					ext = (t == T_ADDI) ? {{17{imm[14]}}, imm} : {17'd0, imm};
					op = (t == T_ADDI) ? `ADDI : (t == T_ORI) ? `ORI : `XORI;
					emit(enc_imm(op, 5'd3, 5'd1, imm));
					store_slot(name, 5'd3, model(t, a, ext), 1'b1);
				end
				T_LWI: begin
					imm = 15'(64 + slot);
					store_slot(name, 5'd1, a, 1'b1);
					emit(enc_imm(`LWI, 5'd3, 5'd0, imm));
					store_slot(name, 5'd3, a, 1'b1);
				end
				T_LW: begin
					addr = 32'h1000 + slot * 16;
					movi(5'd2, addr >> sv);
					emit(enc_reg(`TY_LS, 5'd1, 5'd0, 5'd2, sv, `SW));
					expect_store(name, addr, a);
					emit(enc_reg(`TY_LS, 5'd3, 5'd0, 5'd2, sv, `LW));
					store_slot(name, 5'd3, a, 1'b1);
					sv = sv + 2'd1;
				end
				default: begin
					taken = (t == T_BEQ_TAKEN || t == T_BNE_TAKEN || t == T_JJ);
					b = (t == T_BEQ_TAKEN || t == T_BNE_NOT) ? a : sext20(a + 32'd1);
					movi(5'd2, b);
					if (t == T_JJ) begin
						emit(enc_imm(`JJ, 5'd0, 5'd0, 15'd4));
					end else begin
						op = `TY_B;
						emit(enc_imm(op, 5'd1, 5'd2,
							{t == T_BNE_TAKEN || t == T_BNE_NOT, 14'd4}));
					end
					store_slot({name, "_marker"}, 5'd2, b, !taken);
					store_slot(name, 5'd1, a, 1'b1);
				end
			endcase
		end
		// park the core on a jump to itself
		emit(enc_imm(`JJ, 5'd0, 5'd0, 15'd0));
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "value check failed");
		end
	endtask

	initial begin
		int cycle;
		int last;
		int waited;
		reset = 1'b1;
		instruction = '0;
		dm_rdata = '0;
		cycle = 0;
		last = 0;
		build_program();
		repeat (10) begin
			@(negedge clock);
			check("reset strobes", 32'd0, {30'd0, dm_read, dm_write});
		end
		reset = 1'b0;
		check("first fetch address", `RESET_PC, im_addr);
		for (int i = 0; i < exp_addr.size(); i++) begin
			waited = 0;
			do begin
				@(negedge clock);
				cycle++;
				waited++;
			end while (!dm_write && waited < 100);
			if (!dm_write) begin
				$display("store %0d of %s never came within 100 cycles", i, exp_name[i]);
				$display("*** FAILED ***");
				$fatal(1, "store timeout");
			end
			check({exp_name[i], " address"}, exp_addr[i], dm_addr);
			check({exp_name[i], " data"}, exp_data[i], dm_wdata);
			if (i > 0) begin
				check({exp_name[i], " spacing"}, 32'd0, (cycle - last) % 5);
			end
			last = cycle;
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/controller.sv
source/datapath.sv
source/cpu_top.sv
dv/cpu_assertions.sv
dv/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := cpu_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) source/cpu_params.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
